// ==== common/cc_pkg.sv ====
package cc_pkg;

    // shared bus widths
    localparam int CC_AW = 32;          // byte address width
    localparam int CC_DW = 32;          // data width

    // transfer size codes on the two-bit size lines
    localparam logic [1 : 0] SIZE_BYTE = 2'd0;   // one byte lane
    localparam logic [1 : 0] SIZE_HALF = 2'd1;   // two lanes, half aligned
    localparam logic [1 : 0] SIZE_WORD = 2'd2;   // all four lanes

    // ram geometry
    localparam int MEM_WORDS = 256;     // depth in 32-bit words
    localparam int MEM_AW    = 8;       // word index width, addr bits above bit 1

    // wait states counted before each access
    localparam int MEM_WAIT   = 2;
    localparam int MEM_WAIT_W = $clog2(MEM_WAIT + 1);   // wait counter width

    // one-hot master select codes for the cross connect
    localparam logic [1 : 0] MASTER_0    = 2'b01;   // instruction fetch side
    localparam logic [1 : 0] MASTER_1    = 2'b10;   // load/store side
    localparam logic [1 : 0] MASTER_NONE = 2'b00;   // bus parked, no master

endpackage : cc_pkg

// ==== logic/cc_arbiter.sv ====
`timescale 1ns/1ps

module cc_arbiter
    import cc_pkg::*;
(
    input   logic   [0 : 0]         clk,            // clock
    input   logic   [0 : 0]         resetn,         // async reset, active low
    // instruction fetch master
    input   logic   [CC_AW-1 : 0]   addr_if_i,      // byte address
    input   logic   [CC_DW-1 : 0]   wd_if_i,        // write data
    input   logic   [1 : 0]         size_if_i,      // size code
    input   logic   [0 : 0]         we_if_i,        // write enable
    input   logic   [0 : 0]         req_if_i,       // request strobe
    output  logic   [CC_DW-1 : 0]   rd_if_o,        // read data
    output  logic   [0 : 0]         req_ack_if_o,   // acknowledge
    // load/store master
    input   logic   [CC_AW-1 : 0]   addr_dm_i,      // byte address
    input   logic   [CC_DW-1 : 0]   wd_dm_i,        // write data
    input   logic   [1 : 0]         size_dm_i,      // size code
    input   logic   [0 : 0]         we_dm_i,        // write enable
    input   logic   [0 : 0]         req_dm_i,       // request strobe
    output  logic   [CC_DW-1 : 0]   rd_dm_o,        // read data
    output  logic   [0 : 0]         req_ack_dm_o,   // acknowledge
    // shared bus toward the slave
    output  logic   [CC_AW-1 : 0]   addr_cc_o,      // muxed address
    output  logic   [CC_DW-1 : 0]   wd_cc_o,        // muxed write data
    output  logic   [1 : 0]         size_cc_o,      // muxed size
    output  logic   [0 : 0]         we_cc_o,        // muxed write enable
    output  logic   [0 : 0]         req_cc_o,       // muxed request
    input   logic   [CC_DW-1 : 0]   rd_cc_i,        // slave read data
    input   logic   [0 : 0]         req_ack_cc_i    // slave acknowledge
);

    logic   [1 : 0]     sel_out;        // fsm state, also selects the request bundle
    logic   [1 : 0]     sel_in;         // owner of read data and acknowledge
    logic   [0 : 0]     last_master;    // 0 after leaving master 0, 1 after master 1
    logic   [0 : 0]     leave_m0;       // master 1 waits and master 0 is done or idle
    logic   [0 : 0]     leave_m1;       // mirror case for master 1

    // only hand over when the owner is not mid-transfer
    assign leave_m0 = req_dm_i && ( !req_if_i || req_ack_cc_i );
    assign leave_m1 = req_if_i && ( !req_dm_i || req_ack_cc_i );

    // response path, the unselected master sees zeros
    assign req_ack_if_o = ( sel_in == MASTER_0 ) ? req_ack_cc_i : '0;
    assign rd_if_o      = ( sel_in == MASTER_0 ) ? rd_cc_i      : '0;
    assign req_ack_dm_o = ( sel_in == MASTER_1 ) ? req_ack_cc_i : '0;
    assign rd_dm_o      = ( sel_in == MASTER_1 ) ? rd_cc_i      : '0;

    // request path
    always_comb
    begin
        addr_cc_o = '0;             // parked bus drives zeros
        wd_cc_o   = '0;
        size_cc_o = '0;
        we_cc_o   = '0;
        req_cc_o  = '0;
        case( sel_out )
            MASTER_0:
            begin
                addr_cc_o = addr_if_i;
                wd_cc_o   = wd_if_i;
                size_cc_o = size_if_i;
                we_cc_o   = we_if_i;
                req_cc_o  = req_if_i;
            end
            MASTER_1:
            begin
                addr_cc_o = addr_dm_i;
                wd_cc_o   = wd_dm_i;
                size_cc_o = size_dm_i;
                we_cc_o   = we_dm_i;
                req_cc_o  = req_dm_i;
            end
            default: ;                  // MASTER_NONE keeps zeros
        endcase
    end

    // grant fsm, idle sits between every handover
    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
        begin
            sel_out     <= MASTER_0;        // fetch side owns the bus after reset
            sel_in      <= MASTER_0;
            last_master <= 1'b0;
        end
        else
        begin
            case( sel_out )
                MASTER_0:
                begin
                    if( leave_m0 )
                    begin
                        sel_out     <= MASTER_NONE;     // drop shared req
                        last_master <= 1'b0;            // sel_in stays for a late ack
                    end
                end
                MASTER_1:
                begin
                    if( leave_m1 )
                    begin
                        sel_out     <= MASTER_NONE;
                        last_master <= 1'b1;
                    end
                end
                MASTER_NONE:
                begin
                    if( !req_ack_cc_i )             // wait for any ack to drain
                    begin
                        sel_out <= last_master ? MASTER_0 : MASTER_1;
                        sel_in  <= last_master ? MASTER_0 : MASTER_1;
                    end
                end
                default:
                begin
                    sel_out <= MASTER_0;            // unused code, back to fetch side
                    sel_in  <= MASTER_0;
                end
            endcase
        end
    end

endmodule : cc_arbiter

// ==== shared_ram/shared_ram.sv ====
`timescale 1ns/1ps

module shared_ram
    import cc_pkg::*;
(
    input   logic   [0 : 0]         clk,        // clock
    input   logic   [0 : 0]         resetn,     // async reset, active low
    input   logic   [CC_AW-1 : 0]   addr_i,     // byte address
    input   logic   [CC_DW-1 : 0]   wd_i,       // write data, low aligned
    input   logic   [1 : 0]         size_i,     // size code
    input   logic   [0 : 0]         we_i,       // write enable
    input   logic   [0 : 0]         req_i,      // request strobe, held until ack
    output  logic   [CC_DW-1 : 0]   rd_o,       // read word, valid with ack
    output  logic   [0 : 0]         req_ack_o   // one cycle acknowledge
);

    logic   [CC_DW-1 : 0]       mem [0 : MEM_WORDS-1];  // word storage
    logic   [MEM_WAIT_W-1 : 0]  wait_cnt;               // edges seen with req high
    logic   [MEM_AW-1 : 0]      word_idx;               // aligned word index
    logic   [0 : 0]             access;                 // wait done, access this edge
    logic   [3 : 0]             lane_en;                // byte lanes to write
    logic   [CC_DW-1 : 0]       wd_lanes;               // write data spread over lanes

    assign word_idx = addr_i[MEM_AW+1 : 2];             // drop byte offset bits

    // no new count during the ack cycle, req is still the old transfer
    assign access = req_i && !req_ack_o && ( wait_cnt == MEM_WAIT_W'(MEM_WAIT) );

    // lane selection from size and low address bits
    always_comb
    begin
        lane_en  = '0;
        wd_lanes = wd_i;
        case( size_i )
            SIZE_BYTE:
            begin
                lane_en[addr_i[1 : 0]] = 1'b1;          // single lane at byte offset
                wd_lanes = {4{wd_i[7 : 0]}};            // byte copied to every lane
            end
            SIZE_HALF:
            begin
                lane_en  = addr_i[1] ? 4'b1100 : 4'b0011;   // upper or lower half
                wd_lanes = {2{wd_i[15 : 0]}};
            end
            SIZE_WORD:
            begin
                lane_en = 4'b1111;                      // full word
            end
            default:
            begin
                lane_en = 4'b0000;                      // code 3 writes nothing
            end
        endcase
    end

    // storage write, one enable per byte lane
    always_ff @(posedge clk)
    begin
        if( access && we_i )
        begin
            for( int lane = 0 ; lane < 4 ; lane++ )
            begin
                if( lane_en[lane] )
                    mem[word_idx][lane*8 +: 8] <= wd_lanes[lane*8 +: 8];
            end
        end
    end

    // wait counter, acknowledge and read latch
    always_ff @(posedge clk, negedge resetn)
    begin
        if( !resetn )
        begin
            wait_cnt  <= '0;
            req_ack_o <= 1'b0;
            rd_o      <= '0;
        end
        else
        begin
            req_ack_o <= 1'b0;                          // pulse only
            if( !req_i || req_ack_o )
                wait_cnt <= '0;                         // dropped req or ack cycle
            else if( access )
            begin
                wait_cnt  <= '0;
                req_ack_o <= 1'b1;
                if( !we_i )
                    rd_o <= mem[word_idx];              // whole aligned word
            end
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule : shared_ram

// ==== logic/cc_top.sv ====
`timescale 1ns/1ps

module cc_top
    import cc_pkg::*;
(
    input   logic   [0 : 0]         clk,            // clock
    input   logic   [0 : 0]         resetn,         // async reset, active low
    // instruction fetch master
    input   logic   [CC_AW-1 : 0]   addr_if_i,
    input   logic   [CC_DW-1 : 0]   wd_if_i,
    input   logic   [1 : 0]         size_if_i,
    input   logic   [0 : 0]         we_if_i,
    input   logic   [0 : 0]         req_if_i,
    output  logic   [CC_DW-1 : 0]   rd_if_o,
    output  logic   [0 : 0]         req_ack_if_o,
    // load/store master
    input   logic   [CC_AW-1 : 0]   addr_dm_i,
    input   logic   [CC_DW-1 : 0]   wd_dm_i,
    input   logic   [1 : 0]         size_dm_i,
    input   logic   [0 : 0]         we_dm_i,
    input   logic   [0 : 0]         req_dm_i,
    output  logic   [CC_DW-1 : 0]   rd_dm_o,
    output  logic   [0 : 0]         req_ack_dm_o
);

    logic   [CC_AW-1 : 0]   addr_cc;        // shared bus, arbiter to ram
    logic   [CC_DW-1 : 0]   wd_cc;
    logic   [1 : 0]         size_cc;
    logic   [0 : 0]         we_cc;
    logic   [0 : 0]         req_cc;
    logic   [CC_DW-1 : 0]   rd_cc;          // ram back to arbiter
    logic   [0 : 0]         req_ack_cc;

    cc_arbiter arb0
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .addr_if_i      ( addr_if_i     ),
        .wd_if_i        ( wd_if_i       ),
        .size_if_i      ( size_if_i     ),
        .we_if_i        ( we_if_i       ),
        .req_if_i       ( req_if_i      ),
        .rd_if_o        ( rd_if_o       ),
        .req_ack_if_o   ( req_ack_if_o  ),
        .addr_dm_i      ( addr_dm_i     ),
        .wd_dm_i        ( wd_dm_i       ),
        .size_dm_i      ( size_dm_i     ),
        .we_dm_i        ( we_dm_i       ),
        .req_dm_i       ( req_dm_i      ),
        .rd_dm_o        ( rd_dm_o       ),
        .req_ack_dm_o   ( req_ack_dm_o  ),
        .addr_cc_o      ( addr_cc       ),
        .wd_cc_o        ( wd_cc         ),
        .size_cc_o      ( size_cc       ),
        .we_cc_o        ( we_cc         ),
        .req_cc_o       ( req_cc        ),
        .rd_cc_i        ( rd_cc         ),
        .req_ack_cc_i   ( req_ack_cc    )
    );

    shared_ram ram0
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .addr_i         ( addr_cc       ),
        .wd_i           ( wd_cc         ),
        .size_i         ( size_cc       ),
        .we_i           ( we_cc         ),
        .req_i          ( req_cc        ),
        .rd_o           ( rd_cc         ),
        .req_ack_o      ( req_ack_cc    )
    );

endmodule : cc_top

// ==== tb/tb_cc_top.sv ====
`timescale 1ns/1ps

module tb_cc_top
    import cc_pkg::*;
();

    logic               clk;
    logic               resetn;
    logic [CC_AW-1 : 0] addr_if, addr_dm;
    logic [CC_DW-1 : 0] wd_if, wd_dm;
    logic [1 : 0]       size_if, size_dm;
    logic               we_if, we_dm, req_if, req_dm;
    logic [CC_DW-1 : 0] rd_if, rd_dm;
    logic               req_ack_if, req_ack_dm;

    logic               t_we   [2][8];          // per master transfer queue
    logic [1 : 0]       t_size [2][8];
    logic [CC_AW-1 : 0] t_addr [2][8];
    logic [CC_DW-1 : 0] t_wd   [2][8];
    logic [CC_DW-1 : 0] t_exp  [2][8];          // expected read word from file
    logic [CC_DW-1 : 0] shadow [MEM_WORDS];     // reference copy of the ram
    logic [1 : 0]       holder;                 // master expected to own the grant
    int                 total;                  // transfers completed

    cc_top dut0
    (
        .clk ( clk ), .resetn ( resetn ),
        .addr_if_i ( addr_if ), .wd_if_i ( wd_if ), .size_if_i ( size_if ),
        .we_if_i ( we_if ), .req_if_i ( req_if ), .rd_if_o ( rd_if ), .req_ack_if_o ( req_ack_if ),
        .addr_dm_i ( addr_dm ), .wd_dm_i ( wd_dm ), .size_dm_i ( size_dm ),
        .we_dm_i ( we_dm ), .req_dm_i ( req_dm ), .rd_dm_o ( rd_dm ), .req_ack_dm_o ( req_ack_dm )
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [CC_DW-1 : 0] got,
                              input logic [CC_DW-1 : 0] exp);
        if( got !== exp )
        begin
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_master(input string name, input logic [1 : 0] got,
                                input logic [1 : 0] exp);
        if( got !== exp )
        begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // cycles from request to acknowledge
    task automatic check_latency(input string name, input int got, input int exp);
        if( got != exp )
        begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // word after a write with lanes picked by size and byte offset
    function automatic logic [CC_DW-1 : 0] merge_lanes(input logic [CC_DW-1 : 0] old,
        input logic [1 : 0] size, input logic [1 : 0] offs, input logic [CC_DW-1 : 0] wd);
        logic [CC_DW-1 : 0] mask;
        logic [CC_DW-1 : 0] data;
        mask = '1;
        data = wd;
        if( size == SIZE_BYTE )
        begin
            mask = 32'h0000_00ff << {offs, 3'b000};             // offset times 8
            data = {24'h0, wd[7 : 0]} << {offs, 3'b000};
        end
        else if( size == SIZE_HALF )
        begin
            mask = 32'h0000_ffff << {offs[1], 4'b0000};         // lower or upper half
            data = {16'h0, wd[15 : 0]} << {offs[1], 4'b0000};
        end
        return ( old & ~mask ) | ( data & mask );
    endfunction

    task automatic present(input int m, input int i);
        if( m == 0 )
        begin
            addr_if <= t_addr[0][i];
            wd_if   <= t_wd[0][i];
            size_if <= t_size[0][i];
            we_if   <= t_we[0][i];
            req_if  <= 1'b1;
        end
        else
        begin
            addr_dm <= t_addr[1][i];
            wd_dm   <= t_wd[1][i];
            size_dm <= t_size[1][i];
            we_dm   <= t_we[1][i];
            req_dm  <= 1'b1;
        end
    endtask

    // ack cycle checks with zero read data expected on the other master
    task automatic complete(input int m, input int i);
        logic [MEM_AW-1 : 0] widx;
        widx = t_addr[m][i][MEM_AW+1 : 2];
        check_word(( m == 0 ) ? "rd_dm_o" : "rd_if_o", ( m == 0 ) ? rd_dm : rd_if, '0);
        if( t_we[m][i] )
            shadow[widx] = merge_lanes(shadow[widx], t_size[m][i], t_addr[m][i][1 : 0],
                                       t_wd[m][i]);
        else
        begin
            check_word("shadow_word", shadow[widx], t_exp[m][i]);   // file agrees with model
            check_word(( m == 0 ) ? "rd_if_o" : "rd_dm_o", ( m == 0 ) ? rd_if : rd_dm,
                       t_exp[m][i]);
        end
        total = total + 1;
    endtask

    // n0 and n1 transfers where each master moves on in the cycle after its ack
    task automatic run_transfers(input int n0, input int n1);
        int         idx [2];
        int         cnt;
        int         last;
        int         m;
        logic [1 : 0] got;
        logic [1 : 0] want;
        idx[0] = 0;
        idx[1] = 0;
        cnt    = 0;
        last   = -1;
        @(posedge clk);
        if( n0 > 0 )
            present(0, 0);
        if( n1 > 0 )
            present(1, 0);
        while( idx[0] < n0 || idx[1] < n1 )
        begin
            @(negedge clk);                     // outputs settled mid cycle
            got = {req_ack_dm, req_ack_if};
            m   = -1;
            if( got != MASTER_NONE )
            begin
                if( idx[0] >= n0 )
                    want = MASTER_1;
                else if( idx[1] >= n1 )
                    want = MASTER_0;
                else if( last < 0 )
                    want = holder;              // grant owner goes first
                else
                    want = ( last == 0 ) ? MASTER_1 : MASTER_0;   // strict alternation
                check_master("ack_owner", got, want);
                if( last < 0 && want == holder )
                    check_latency("ack_latency", cnt, MEM_WAIT + 1);   // owner skips idle
                m = ( got == MASTER_1 ) ? 1 : 0;
                complete(m, idx[m]);
                idx[m] = idx[m] + 1;
                last   = m;
                cnt    = 0;
            end
            else
            begin
                cnt = cnt + 1;
                if( cnt >= 64 )
                begin
                    $display("timeout: no acknowledge arrived within 64 cycles");
                    stop_on_error();
                end
            end
            @(posedge clk);
            if( m >= 0 && idx[m] < (( m == 0 ) ? n0 : n1) )
                present(m, idx[m]);
            else if( m == 0 )
                req_if <= 1'b0;
            else if( m == 1 )
                req_dm <= 1'b0;
        end
        holder = ( last == 1 ) ? MASTER_1 : MASTER_0;   // last acked master keeps grant
    endtask

    task automatic store(input int m, input int i, input logic [31 : 0] we,
        input logic [31 : 0] sz, input logic [31 : 0] a, input logic [31 : 0] w,
        input logic [31 : 0] e);
        t_we[m][i]   = we[0];
        t_size[m][i] = sz[1 : 0];
        t_addr[m][i] = a;
        t_wd[m][i]   = w;
        t_exp[m][i]  = e;
    endtask

    initial
    begin
        int             fd;
        int             rc;
        int             mode;
        int             ns;
        string          line;
        logic [31 : 0]  we0, sz0, a0, w0, e0, we1, sz1, a1, w1, e1;
        resetn  = 1'b0;
        addr_if = '0;
        wd_if   = '0;
        size_if = '0;
        we_if   = 1'b0;
        req_if  = 1'b0;
        addr_dm = '0;
        wd_dm   = '0;
        size_dm = '0;
        we_dm   = 1'b0;
        req_dm  = 1'b0;
        holder  = MASTER_0;                     // fetch side owns the bus after reset
        total   = 0;
        ns      = 0;
        for( int k = 0 ; k < MEM_WORDS ; k++ )
            shadow[k] = '0;
        fd = $fopen("tb/cc_tests.txt", "r");
        if( fd == 0 )
        begin
            $display("could not open the test file tb/cc_tests.txt");
            stop_on_error();
        end
        repeat( 16 ) @(posedge clk);
        resetn <= 1'b1;
        while( !$feof(fd) )
        begin
            line = "";
            rc   = $fgets(line, fd);
            if( rc == 0 || line.len() < 2 || line[0] == 8'h23 )   // blank or # comment
                continue;
            rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h",
                         mode, we0, sz0, a0, w0, e0, we1, sz1, a1, w1, e1);
            if( rc != 11 || mode < 0 || mode > 3 || ( mode == 3 && ns == 8 ) )
            begin
                $display("bad line in the test file: %s", line);
                stop_on_error();
            end
            if( mode != 3 && ns > 0 )
            begin
                run_transfers(ns, ns);          // flush a pending stream
                ns = 0;
            end
            store(0, ( mode == 3 ) ? ns : 0, we0, sz0, a0, w0, e0);
            store(1, ( mode == 3 ) ? ns : 0, we1, sz1, a1, w1, e1);
            case( mode )
                0:       run_transfers(1, 0);
                1:       run_transfers(0, 1);
                2:       run_transfers(1, 1);
                default: ns = ns + 1;           // stream entry that runs later
            endcase
        end
        if( ns > 0 )
            run_transfers(ns, ns);
        $fclose(fd);
        repeat( 4 ) @(posedge clk);
        if( total > 0 )
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("no transfers were read from the test file");
            stop_on_error();
        end
    end

endmodule : tb_cc_top

// ==== tb/cc_tests.txt ====
# mode (0 master 0 alone, 1 master 1 alone, 2 pair, 3 stream entry), then per master:
# we size addr wdata expected_rd, all hex, expected_rd used on reads only
0 1 2 00000010 cafef00d 00000000  0 0 00000000 00000000 00000000
0 0 2 00000010 00000000 cafef00d  0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000  0 2 00000010 00000000 cafef00d
1 0 0 00000000 00000000 00000000  1 2 00000020 11223344 00000000
1 0 0 00000000 00000000 00000000  1 2 00000024 55667788 00000000
1 0 0 00000000 00000000 00000000  1 2 000003fc a5a5a5a5 00000000
0 0 2 00000020 00000000 11223344  0 0 00000000 00000000 00000000
0 0 2 00000024 00000000 55667788  0 0 00000000 00000000 00000000
0 0 2 000003fc 00000000 a5a5a5a5  0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000  1 2 00000040 00000000 00000000
1 0 0 00000000 00000000 00000000  1 0 00000040 123456a1 00000000
0 1 0 00000041 000000b2 00000000  0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000  1 0 00000042 ffffffc3 00000000
0 1 0 00000043 000000d4 00000000  0 0 00000000 00000000 00000000
0 0 2 00000040 00000000 d4c3b2a1  0 0 00000000 00000000 00000000
0 1 2 00000044 11111111 00000000  0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000  1 1 00000044 9999beef 00000000
0 0 2 00000044 00000000 1111beef  0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000  1 1 00000046 8888dead 00000000
1 0 0 00000000 00000000 00000000  0 2 00000044 00000000 deadbeef
0 1 0 00000045 00000077 00000000  0 0 00000000 00000000 00000000
1 0 0 00000000 00000000 00000000  0 2 00000044 00000000 dead77ef
2 0 2 00000020 00000000 11223344  0 2 00000024 00000000 55667788
2 1 2 00000080 01020304 00000000  0 2 00000040 00000000 d4c3b2a1
2 0 2 00000080 00000000 01020304  1 2 00000084 0a0b0c0d 00000000
3 1 2 00000100 aaaa0001 00000000  1 2 00000200 bbbb0001 00000000
3 0 2 00000100 00000000 aaaa0001  1 0 00000201 000000cc 00000000
3 1 1 00000102 0000f00f 00000000  0 2 00000200 00000000 bbbbcc01
3 0 2 00000100 00000000 f00f0001  0 2 00000084 00000000 0a0b0c0d
1 0 0 00000000 00000000 00000000  0 2 00000100 00000000 f00f0001

// ==== sources.f ====
common/cc_pkg.sv
logic/cc_arbiter.sv
shared_ram/shared_ram.sv
logic/cc_top.sv
tb/tb_cc_top.sv

// ==== Makefile ====
# Verilator build and run of the cross connect testbench
VERILATOR ?= verilator
TOP       ?= tb_cc_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
